// ==== design/timetag_pkg.sv ====
package timetag_pkg;

	localparam int N_DET = 4;  // Detector and laser channels

	typedef enum logic [7:0] {
		OP_NOP        = 8'h00,
		OP_WRITE_BYTE = 8'h01,  // Address, then one value byte
		OP_RESET_TIME = 8'h02,
		OP_WRITE_WORD = 8'h05   // Address, then four value bytes, MSB first
	} opcode_t;

	// Register map
	localparam logic [7:0] REG_CTRL       = 8'h01;  // Bit0 tagger run, bit1 sequencer run
	localparam logic [7:0] REG_DET_MASK   = 8'h02;
	localparam logic [7:0] REG_HOLDOFF    = 8'h03;
	localparam logic [7:0] REG_SEQ_PERIOD = 8'h04;
	localparam logic [7:0] REG_SEQ_HIGH   = 8'h05;
	localparam logic [7:0] REG_LASER_MASK = 8'h06;

	typedef struct packed {
		logic             tag_run;
		logic             seq_run;
		logic [N_DET-1:0] det_mask;
		logic [7:0]       holdoff;     // Retrigger block in cycles
		logic [31:0]      seq_period;
		logic [31:0]      seq_high;    // Laser on while phase is below this
		logic [N_DET-1:0] laser_mask;
		logic             time_clear;  // One cycle pulse
	} ctrl_regs_t;

	// One timestamped record, sent as five bytes
	typedef struct packed {
		logic             overflow;   // Records were dropped before this one
		logic [1:0]       unused;
		logic             marker;     // Sequencer period start
		logic [N_DET-1:0] det;
		logic [31:0]      timestamp;
	} record_t;

endpackage

// ==== design/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [7:0]              cmd_data,
	input  logic                    cmd_wr,
	output timetag_pkg::ctrl_regs_t regs,
	output logic                    running
);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA
	} state_t;

	state_t               state;
	timetag_pkg::opcode_t op;         // Opcode of the command in progress
	logic [7:0]           addr;
	logic [2:0]           byte_cnt;   // Value bytes taken so far
	logic [23:0]          value_hi;   // Upper bytes of a word write
	logic [31:0]          value;
	logic                 last_byte;

	assign value = (op == timetag_pkg::OP_WRITE_WORD) ? {value_hi, cmd_data} : {24'd0, cmd_data};
	assign last_byte = (op == timetag_pkg::OP_WRITE_WORD) ? (byte_cnt == 3'd3) : 1'b1;
	assign running = regs.tag_run;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			op       <= timetag_pkg::OP_NOP;
			addr     <= '0;
			byte_cnt <= '0;
			value_hi <= '0;
			regs     <= '0;
		end else begin
			regs.time_clear <= 1'b0;  // Pulse only
			if (cmd_wr) begin
				case (state)
					IDLE: begin
						case (cmd_data)
							timetag_pkg::OP_WRITE_BYTE, timetag_pkg::OP_WRITE_WORD: begin
								op    <= timetag_pkg::opcode_t'(cmd_data);
								state <= ADDR;
							end
							timetag_pkg::OP_RESET_TIME: regs.time_clear <= 1'b1;
							default: ;  // Junk and NOP bytes fall through
						endcase
					end
					ADDR: begin
						addr     <= cmd_data;
						byte_cnt <= '0;
						value_hi <= '0;
						state    <= DATA;
					end
					DATA: begin
						value_hi <= {value_hi[15:0], cmd_data};
						byte_cnt <= byte_cnt + 3'd1;
						if (last_byte) begin
							state <= IDLE;
							case (addr)
								timetag_pkg::REG_CTRL: begin
									regs.tag_run <= value[0];
									regs.seq_run <= value[1];
								end
								timetag_pkg::REG_DET_MASK:   regs.det_mask <= value[3:0];
								timetag_pkg::REG_HOLDOFF:    regs.holdoff <= value[7:0];
								timetag_pkg::REG_SEQ_PERIOD: regs.seq_period <= value;
								timetag_pkg::REG_SEQ_HIGH:   regs.seq_high <= value;
								timetag_pkg::REG_LASER_MASK: regs.laser_mask <= value[3:0];
								default: ;  // Unknown address
							endcase
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// A word write takes four value bytes and then returns to IDLE
	a_byte_cnt: assert property (@(posedge clk) disable iff (!rst_n)
		byte_cnt <= 3'd4);

endmodule

// ==== design/photon_tagger.sv ====
`timescale 1ns/1ps

module photon_tagger #(
	parameter int SYNC_STAGES = 2
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [timetag_pkg::N_DET-1:0]   detectors,
	input  timetag_pkg::ctrl_regs_t         regs,
	output logic [timetag_pkg::N_DET-1:0]   det_hit
);

	localparam int N = timetag_pkg::N_DET;

	logic [N-1:0] sync [SYNC_STAGES];  // Metastability chain
	logic [N-1:0] sync_prev;
	logic [N-1:0] edge_q;              // Registered rising edge
	logic [7:0]   hold_cnt [N];
	logic [N-1:0] hit_now;

	always_comb begin
		for (int i = 0; i < N; i++) begin
			hit_now[i] = edge_q[i] & regs.det_mask[i] & (hold_cnt[i] == 8'd0);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < SYNC_STAGES; s++) begin
				sync[s] <= '0;
			end
			sync_prev <= '0;
			edge_q    <= '0;
			det_hit   <= '0;
			for (int i = 0; i < N; i++) begin
				hold_cnt[i] <= '0;
			end
		end else begin
			sync[0] <= detectors;
			for (int s = 1; s < SYNC_STAGES; s++) begin
				sync[s] <= sync[s-1];
			end
			sync_prev <= sync[SYNC_STAGES-1];
			edge_q    <= sync[SYNC_STAGES-1] & ~sync_prev;
			det_hit   <= hit_now;
			for (int i = 0; i < N; i++) begin
				if (hit_now[i])
					hold_cnt[i] <= regs.holdoff;  // Start the dead time
				else if (hold_cnt[i] != 8'd0)
					hold_cnt[i] <= hold_cnt[i] - 8'd1;
			end
		end
	end

	// A busy holdoff counter must block the hit in the following cycle
	for (genvar g = 0; g < N; g++) begin : g_holdoff_chk
		a_holdoff: assert property (@(posedge clk) disable iff (!rst_n)
			(hold_cnt[g] != 8'd0) |=> !det_hit[g]);
	end

endmodule

// ==== design/pulse_sequencer.sv ====
`timescale 1ns/1ps

module pulse_sequencer (
	input  logic                            clk,
	input  logic                            rst_n,
	input  timetag_pkg::ctrl_regs_t         regs,
	output logic [timetag_pkg::N_DET-1:0]   laser_en,
	output logic                            seq_mark
);

	logic [31:0] phase;
	logic        active;
	logic        wrap;

	// A zero period counts as stopped
	assign active = regs.seq_run && (regs.seq_period != 32'd0);
	assign wrap = (phase >= regs.seq_period - 32'd1);  // Also catches a shortened period

	always_ff @(posedge clk) begin
		if (!rst_n || !active)
			phase <= '0;
		else if (wrap)
			phase <= '0;
		else
			phase <= phase + 32'd1;
	end

	always_comb begin
		laser_en = '0;
		seq_mark = 1'b0;
		if (active) begin
			if (phase < regs.seq_high)
				laser_en = regs.laser_mask;
			seq_mark = (phase == 32'd0);
		end
	end

	// Each period starts in the laser on window unless that window is empty
	a_mark_window: assert property (@(posedge clk) disable iff (!rst_n)
		seq_mark |-> (laser_en == regs.laser_mask || regs.seq_high == 32'd0));

endmodule

// ==== design/record_merge.sv ====
`timescale 1ns/1ps

module record_merge #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  timetag_pkg::ctrl_regs_t         regs,
	input  logic [timetag_pkg::N_DET-1:0]   det_hit,
	input  logic                            seq_mark,
	output logic [7:0]                      data,
	output logic                            data_avail,
	input  logic                            data_accepted
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW:0] FULL_CNT = (AW+1)'(FIFO_DEPTH);
	localparam int RW = $bits(timetag_pkg::record_t);

	logic [31:0]          timebase;
	logic                 overflow;    // Sticky until the next stored record
	timetag_pkg::record_t new_rec;
	logic                 event_now;
	logic                 full;
	logic                 wr_en;
	logic                 rd_en;
	timetag_pkg::record_t mem [FIFO_DEPTH];
	logic [AW-1:0]        wr_ptr;
	logic [AW-1:0]        rd_ptr;
	logic [AW:0]          count;
	logic [RW-1:0]        shreg;       // Record being sent, current byte on top
	logic [2:0]           byte_idx;
	logic                 busy;
	logic                 last_accept;

	always_ff @(posedge clk) begin
		if (!rst_n || regs.time_clear)
			timebase <= '0;
		else if (regs.tag_run)
			timebase <= timebase + 32'd1;
	end

	// Merge of this cycle's events
	always_comb begin
		new_rec.overflow  = overflow;
		new_rec.unused    = 2'b00;
		new_rec.marker    = seq_mark;
		new_rec.det       = det_hit;
		new_rec.timestamp = timebase;
	end

	assign event_now = (|det_hit) || seq_mark;
	assign full = (count == FULL_CNT);
	assign wr_en = event_now && !full;

	assign last_accept = busy && data_accepted && (byte_idx == 3'd4);
	assign rd_en = (count != '0) && (!busy || last_accept);

	assign data = shreg[RW-1 -: 8];
	assign data_avail = busy;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= new_rec;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(wr_en) - (AW+1)'(rd_en);
			if (event_now && full)
				overflow <= 1'b1;  // Record dropped
			else if (wr_en)
				overflow <= 1'b0;  // Flag left with this record
		end
	end

	// Five byte serializer, header first
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			byte_idx <= '0;
		end else if (rd_en) begin
			busy     <= 1'b1;
			byte_idx <= '0;
		end else if (busy && data_accepted) begin
			if (byte_idx == 3'd4)
				busy <= 1'b0;
			else
				byte_idx <= byte_idx + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			shreg <= mem[rd_ptr];
		else if (busy && data_accepted)
			shreg <= shreg << 8;
	end

	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> count != FULL_CNT);

	a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> count != '0);

endmodule

// ==== design/timetag_top.sv ====
`timescale 1ns/1ps

module timetag_top #(
	parameter int FIFO_DEPTH  = 16,
	parameter int SYNC_STAGES = 2
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [7:0]                      cmd_data,
	input  logic                            cmd_wr,
	input  logic [timetag_pkg::N_DET-1:0]   detectors,
	input  logic                            data_accepted,
	output logic [timetag_pkg::N_DET-1:0]   laser_en,
	output logic                            running,
	output logic [7:0]                      data,
	output logic                            data_avail
);

	timetag_pkg::ctrl_regs_t             regs;
	logic [timetag_pkg::N_DET-1:0]       det_hit;
	logic                                seq_mark;  // Period start strobe

	cmd_parser cmd_parser (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd_data (cmd_data),
		.cmd_wr   (cmd_wr),
		.regs     (regs),
		.running  (running)
	);

	photon_tagger #(
		.SYNC_STAGES (SYNC_STAGES)
	) photon_tagger (
		.clk       (clk),
		.rst_n     (rst_n),
		.detectors (detectors),
		.regs      (regs),
		.det_hit   (det_hit)
	);

	pulse_sequencer pulse_sequencer (
		.clk      (clk),
		.rst_n    (rst_n),
		.regs     (regs),
		.laser_en (laser_en),
		.seq_mark (seq_mark)
	);

	record_merge #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) record_merge (
		.clk           (clk),
		.rst_n         (rst_n),
		.regs          (regs),
		.det_hit       (det_hit),
		.seq_mark      (seq_mark),
		.data          (data),
		.data_avail    (data_avail),
		.data_accepted (data_accepted)
	);

endmodule

// ==== bench/timetag_tb.sv ====
`timescale 1ns/1ps

module timetag_tb;

	localparam int FIFO_DEPTH  = 16;
	localparam int SYNC_STAGES = 2;

	logic       clk = 1'b0;
	logic       rst_n = 1'b0;
	logic [7:0] cmd_data = 8'h00;
	logic       cmd_wr = 1'b0;
	logic [3:0] detectors = 4'h0;
	logic       data_accepted = 1'b0;
	logic [3:0] laser_en;
	logic       running;
	logic [7:0] data;
	logic       data_avail;

	// Reference model state
	timetag_pkg::ctrl_regs_t m_regs;
	logic [31:0]             m_time;
	logic [31:0]             m_phase;
	logic [3:0]              m_prev_det;
	logic [3:0]              m_hit;
	logic [3:0]              m_rdl [SYNC_STAGES+1];  // Rising edges on their way to a hit
	logic [7:0]              m_hold [4];
	logic                    m_active;
	logic                    m_mark;
	logic [3:0]              m_laser;
	timetag_pkg::record_t    exp_q [$];
	int                      p_state;
	logic [7:0]              p_op;
	logic [7:0]              p_addr;
	int                      p_cnt;
	logic [31:0]             p_val;

	logic [31:0] rng = 32'd7948;
	string       cur_test = "reset";
	logic        acc_en = 1'b0;
	logic        bp_phase = 1'b0;
	logic        ovf_seen = 1'b0;
	int          bp_count = 0;
	int          rx_n = 0;
	int          rx_done = 0;
	int          rx_seen = 0;
	int          rx_coinc = 0;  // Received records with marker and det both set
	logic [39:0] rx_rec;
	logic [39:0] rx_full;

	timetag_top uut (.*);

	initial begin
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int rand_below(int n);
		return int'(next_rand() % 32'(n));
	endfunction

	function automatic logic [3:0] pick_channels(logic [3:0] mask);
		logic [3:0] c;
		c = 4'(next_rand()) & mask;
		return (c == 4'h0) ? mask : c;
	endfunction

	// Keeps the sequencer slow enough for the serializer
	function automatic logic [31:0] reg_value(logic [7:0] addr);
		case (addr)
			timetag_pkg::REG_SEQ_PERIOD: return 32'(8 + rand_below(40));
			timetag_pkg::REG_SEQ_HIGH:   return 32'(rand_below(48));
			timetag_pkg::REG_CTRL:       return 32'(rand_below(4));
			default:                     return next_rand();
		endcase
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_val(input string what, input logic [63:0] expv, input logic [63:0] actv);
		if (expv !== actv)
			abort_run($sformatf("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, expv, actv));
	endtask

	task automatic handle_record(input timetag_pkg::record_t r);
		timetag_pkg::record_t e;
		if (exp_q.size() == 0) begin
			abort_run($sformatf("Record %0d came out of the DUT with no event behind it", rx_seen));
		end else if (bp_phase && r.overflow) begin
			if (bp_count != FIFO_DEPTH && bp_count != FIFO_DEPTH + 1)
				abort_run($sformatf("Back-pressure kept %0d records", bp_count));
			e = exp_q[$];  // Next stored record after the drops
			e.overflow = 1'b1;
			exp_q.delete();
			ovf_seen = 1'b1;
			check_val("overflow record", 64'(e), 64'(r));
		end else begin
			e = exp_q.pop_front();
			bp_count += int'(bp_phase);
			check_val($sformatf("record %0d", rx_seen), 64'(e), 64'(r));
			if (r.marker && r.det != 4'h0)
				rx_coinc++;
		end
	endtask

	assign m_active = m_regs.seq_run && (m_regs.seq_period != 32'd0);
	assign m_mark = m_active && (m_phase == 32'd0);
	assign m_laser = (m_active && m_phase < m_regs.seq_high) ? m_regs.laser_mask : 4'h0;

	always @(posedge clk) begin
		logic [3:0] hit_now;
		if (!rst_n) begin
			m_regs <= '0;
			m_time <= '0;
			m_phase <= '0;
			m_prev_det <= '0;
			m_hit <= '0;
			for (int i = 0; i < 4; i++)
				m_hold[i] <= '0;
			for (int s = 0; s <= SYNC_STAGES; s++)
				m_rdl[s] <= '0;
			p_state = 0;
		end else begin
			if (rx_done != rx_seen) begin
				rx_seen++;
				handle_record(rx_full);
			end
			if (m_hit != 4'h0 || m_mark) begin  // One record per event cycle
				exp_q.push_back({1'b0, 2'b00, m_mark, m_hit, m_time});
			end
			m_time <= m_regs.time_clear ? 32'd0 : m_time + 32'(m_regs.tag_run);
			m_phase <= (!m_active || m_phase + 32'd1 >= m_regs.seq_period) ? 32'd0 : m_phase + 32'd1;
			for (int i = 0; i < 4; i++) begin
				hit_now[i] = m_rdl[SYNC_STAGES][i] & m_regs.det_mask[i] & (m_hold[i] == 8'd0);
				m_hold[i] <= hit_now[i] ? m_regs.holdoff
					: (m_hold[i] != 8'd0) ? m_hold[i] - 8'd1 : 8'd0;
			end
			m_hit <= hit_now;
			m_rdl[0] <= detectors & ~m_prev_det;
			for (int s = 1; s <= SYNC_STAGES; s++)
				m_rdl[s] <= m_rdl[s-1];
			m_prev_det <= detectors;
			m_regs.time_clear <= 1'b0;
			if (cmd_wr) begin
				case (p_state)
					0: begin
						if (cmd_data == timetag_pkg::OP_WRITE_BYTE || cmd_data == timetag_pkg::OP_WRITE_WORD) begin
							p_op = cmd_data;
							p_state = 1;
						end else if (cmd_data == timetag_pkg::OP_RESET_TIME) begin
							m_regs.time_clear <= 1'b1;
						end
					end
					1: begin
						p_addr = cmd_data;
						p_cnt = 0;
						p_val = '0;
						p_state = 2;
					end
					default: begin
						p_val = {p_val[23:0], cmd_data};
						p_cnt++;
						if (p_op == timetag_pkg::OP_WRITE_BYTE || p_cnt == 4) begin
							p_state = 0;
							case (p_addr)
								timetag_pkg::REG_CTRL: begin
									m_regs.tag_run <= p_val[0];
									m_regs.seq_run <= p_val[1];
								end
								timetag_pkg::REG_DET_MASK:   m_regs.det_mask <= p_val[3:0];
								timetag_pkg::REG_HOLDOFF:    m_regs.holdoff <= p_val[7:0];
								timetag_pkg::REG_SEQ_PERIOD: m_regs.seq_period <= p_val;
								timetag_pkg::REG_SEQ_HIGH:   m_regs.seq_high <= p_val;
								timetag_pkg::REG_LASER_MASK: m_regs.laser_mask <= p_val[3:0];
								default: ;
							endcase
						end
					end
				endcase
			end
		end
	end

	// Output checks and byte capture, both away from the rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			check_val("running", 64'(m_regs.tag_run), 64'(running));
			check_val("laser_en", 64'(m_laser), 64'(laser_en));
		end
		data_accepted = acc_en;
		if (rst_n && data_avail && acc_en) begin
			rx_rec = {rx_rec[31:0], data};
			rx_n = (rx_n == 4) ? 0 : rx_n + 1;
			if (rx_n == 0) begin
				rx_full = rx_rec;
				rx_done++;
			end
		end
	end

	task automatic send_byte(input logic [7:0] b);
		@(negedge clk);
		cmd_data = b;
		cmd_wr = 1'b1;
		@(negedge clk);
		cmd_wr = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] val, input logic word);
		send_byte(word ? timetag_pkg::OP_WRITE_WORD : timetag_pkg::OP_WRITE_BYTE);
		send_byte(addr);
		if (word)
			for (int i = 3; i >= 1; i--)
				send_byte(val[8*i +: 8]);
		send_byte(val[7:0]);
	endtask

	task automatic photon(input logic [3:0] ch, input int hi, input int gap);
		@(negedge clk);
		detectors = ch;
		repeat (hi) @(negedge clk);
		detectors = 4'h0;
		repeat (gap) @(negedge clk);
	endtask

	task automatic wait_empty();
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			if (++t > 3000)
				abort_run($sformatf("Timeout in %s waiting for record %0d", cur_test, rx_seen + 1));
		end
	endtask

	// FIFO is drained once data_avail stays low for a while
	task automatic wait_idle();
		int t;
		int quiet;
		t = 0;
		quiet = 0;
		while (quiet < 10) begin
			@(negedge clk);
			quiet = data_avail ? 0 : quiet + 1;
			if (++t > 3000)
				abort_run($sformatf("Timeout in %s waiting for data_avail to drop after record %0d",
					cur_test, rx_seen));
		end
	endtask

	task automatic wait_phase(input logic [31:0] p);
		int t;
		t = 0;
		while (m_phase != p) begin
			@(negedge clk);
			if (++t > 200)
				abort_run($sformatf("Timeout in %s waiting for sequencer phase %0d", cur_test, p));
		end
	endtask

	initial begin
		logic [7:0] addr;
		logic [3:0] mask;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		acc_en = 1'b1;
		check_val("data_avail", 64'd0, 64'(data_avail));

		cur_test = "register writes";
		repeat (16) begin
			addr = 8'(1 + rand_below(7));  // 0x07 is not mapped
			if (rand_below(3) == 0)
				send_byte(8'(8'h10 + rand_below(64)));
			write_reg(addr, reg_value(addr), rand_below(2) == 1);
		end
		repeat (200) @(negedge clk);
		write_reg(timetag_pkg::REG_CTRL, 32'd0, 1'b0);
		wait_empty();

		cur_test = "detector tagging";
		mask = 4'(1 + rand_below(15));
		write_reg(timetag_pkg::REG_DET_MASK, 32'(mask), 1'b0);
		write_reg(timetag_pkg::REG_HOLDOFF, 32'd0, 1'b0);
		write_reg(timetag_pkg::REG_CTRL, 32'd1, 1'b1);
		repeat (30)
			photon(pick_channels(mask), 2 + rand_below(3), 4 + rand_below(6));
		wait_empty();

		cur_test = "holdoff";
		write_reg(timetag_pkg::REG_DET_MASK, 32'hF, 1'b0);
		write_reg(timetag_pkg::REG_HOLDOFF, 32'd20, 1'b0);
		repeat (25)
			photon(pick_channels(4'b0011), 2, 2 + rand_below(4));
		wait_empty();

		cur_test = "merge";
		write_reg(timetag_pkg::REG_HOLDOFF, 32'd0, 1'b0);
		write_reg(timetag_pkg::REG_SEQ_PERIOD, 32'd24, 1'b1);
		write_reg(timetag_pkg::REG_SEQ_HIGH, 32'd6, 1'b1);
		write_reg(timetag_pkg::REG_LASER_MASK, 32'(pick_channels(4'hF)), 1'b0);
		write_reg(timetag_pkg::REG_CTRL, 32'd3, 1'b0);
		repeat (20) begin
			if (rand_below(2) == 0)
				wait_phase(32'd19);  // Hit then lands on a period start
			photon(pick_channels(4'hF), 2 + rand_below(3), 6 + rand_below(8));
		end
		write_reg(timetag_pkg::REG_CTRL, 32'd1, 1'b0);
		wait_empty();
		check_val("coincident records", 64'd1, 64'(rx_coinc != 0));

		cur_test = "reset time";
		repeat (50) @(negedge clk);
		send_byte(timetag_pkg::OP_RESET_TIME);
		repeat (8)
			photon(pick_channels(4'hF), 2, 4 + rand_below(6));
		wait_empty();

		cur_test = "back-pressure";
		write_reg(timetag_pkg::REG_DET_MASK, 32'h1, 1'b0);
		wait_idle();
		acc_en = 1'b0;
		bp_phase = 1'b1;
		repeat (FIFO_DEPTH + 6)
			photon(4'h1, 2, 2);
		repeat (SYNC_STAGES + 3) @(negedge clk);  // Last hit reaches the FIFO
		acc_en = 1'b1;
		wait_idle();
		photon(4'h1, 2, 2);
		wait_empty();
		check_val("overflow record seen", 64'd1, 64'(ovf_seen));
		bp_phase = 1'b0;
		wait_idle();

		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== all.f ====
design/timetag_pkg.sv
design/cmd_parser.sv
design/photon_tagger.sv
design/pulse_sequencer.sv
design/record_merge.sv
design/timetag_top.sv
bench/timetag_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= timetag_tb
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

SRCS := $(shell cat all.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): all.f $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f all.f

run: $(BIN)
	@out=$$($(BIN)); echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)
